/* sources.f */
+incdir+test
src/autocat_pkg.sv
src/way_tag_array.sv
src/hit_counter_array.sv
src/epoch_control.sv
src/waymask_suggest.sv
src/autocat_top.sv
test/autocat_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary -j 0 -Wno-fatal --top-module autocat_tb -f sources.f -Mdir obj_dir
	./obj_dir/Vautocat_tb > sim.log 2>&1; cat sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/autocat_model.svh */
`ifndef AUTOCAT_MODEL_SVH
`define AUTOCAT_MODEL_SVH

logic [TAG_LEN - 1:0] m_tag [WAYS];
logic [WAYS - 1:0]    m_valid;
logic [WAYS - 1:0]    m_mask;
logic [WAYS - 1:0]    m_next_mask;
bit                   m_pending;
int                   m_apply_edge;
int                   m_last;
int                   m_counts [WAYS];
int                   m_accesses;
int                   error_count;
int                   check_count;

task automatic model_reset();
    m_valid    = '0;
    m_mask     = '1; // every way open after reset.
    m_pending  = 1'b0;
    m_last     = WAYS - 1;
    m_accesses = 0;
    foreach (m_counts[w])
        m_counts[w] = 0;
endtask

// mask register loads on the apply edge.
task automatic model_catch_up(input int edge_n);
    if (m_pending && edge_n >= m_apply_edge)
    begin
        m_mask    = m_next_mask;
        m_pending = 1'b0;
    end
endtask

function automatic logic [WAYS - 1:0] share_mask();
    int                total;
    logic [WAYS - 1:0] mask;
    total = 0;
    foreach (m_counts[w])
        total += m_counts[w];
    if (total == 0)
        return '1;
    for (int w = 0; w < WAYS; w++)
        mask[w] = (m_counts[w] * WAYS >= total); // at least an average share.
    return mask;
endfunction

task automatic model_access(input logic [TAG_LEN - 1:0] tag, input int edge_n,
                            output logic [WAYS - 1:0] hv);
    int way;
    int cand;
    bit found;
    model_catch_up(edge_n - 1); // mask as seen just before the sampling edge.
    hv  = '0;
    way = -1;
    for (int w = 0; w < WAYS; w++)
        if (m_valid[w] && m_tag[w] == tag)
            way = w;
    if (way >= 0)
    begin
        hv[way] = 1'b1;
        m_counts[way]++;
    end
    else
    begin
        found = 1'b0;
        way   = (m_last + 1) % WAYS;
        for (int k = 1; k <= WAYS; k++)
        begin
            cand = (m_last + k) % WAYS;
            if (!found && m_mask[cand])
            begin
                way   = cand;
                found = 1'b1;
            end
        end
        m_tag[way]   = tag;
        m_valid[way] = 1'b1;
        m_last       = way;
    end
    m_accesses++;
    if (m_accesses == int'(REQUEST_LIMIT))
    begin
        m_next_mask  = share_mask();
        m_pending    = 1'b1;
        m_apply_edge = edge_n + 3 + 2 * WAYS;
        m_accesses   = 0;
        foreach (m_counts[w])
            m_counts[w] = 0;
    end
endtask

task automatic check_hit_vec(input logic [WAYS - 1:0] got, input logic [WAYS - 1:0] exp);
    check_count++;
    if (got !== exp)
    begin
        $display("FAILED hit_vec: got %h, expected %h", got, exp);
        error_count++;
    end
endtask

task automatic check_waymask(input logic [WAYS - 1:0] got, input logic [WAYS - 1:0] exp);
    check_count++;
    if (got !== exp)
    begin
        $display("FAILED suggested_waymask: got %h, expected %h", got, exp);
        error_count++;
    end
endtask

`endif

/* test/autocat_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module autocat_tb
    import autocat_pkg::*;
();

    localparam int            WAYS          = 8;
    localparam int            COUNTER_LEN   = default_counter_len;
    localparam int            TAG_LEN       = default_tag_len;
    localparam access_count_t REQUEST_LIMIT = 16;
    localparam int            LONG_GAP      = 2 * WAYS + 8; // outlasts the mask sequence.
    localparam int            RANDOM_COUNT  = 64;

    logic                 clk_in = 1'b0;
    logic                 reset_with_request_limit;
    logic                 access_valid;
    logic [TAG_LEN - 1:0] access_tag;
    wire  [WAYS - 1:0]    hit_vec;
    wire  [WAYS - 1:0]    suggested_waymask;

    `include "autocat_model.svh"

    logic [TAG_LEN - 1:0] tab_tag [$];
    int                   tab_gap [$];
    int                   tab_way [$]; // -1 for a miss and -2 for model only.
    logic [WAYS - 1:0]    tab_mask [$]; // zero means no mask check.
    string                tab_test [$];

    logic [31:0] lfsr_state = 32'hd384;
    int          edge_n;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          test_count = 0;

    autocat_top #(
        .WAYS          (WAYS),
        .COUNTER_LEN   (COUNTER_LEN),
        .TAG_LEN       (TAG_LEN),
        .REQUEST_LIMIT (REQUEST_LIMIT)
    ) dut0 (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .access_valid             (access_valid),
        .access_tag               (access_tag),
        .hit_vec                  (hit_vec),
        .suggested_waymask        (suggested_waymask)
    );

    always #2 clk_in = ~clk_in;

    always @(posedge clk_in)
    begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
        begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    // one lfsr step per bit taken.
    task automatic take_bits(input int n, output int val);
        logic fb;
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = (val << 1) | int'(fb);
        end
    endtask

    task automatic add_entry(input logic [TAG_LEN - 1:0] tag, input int gap, input int way,
                             input logic [WAYS - 1:0] mask, input string name);
        tab_tag.push_back(tag);
        tab_gap.push_back(gap);
        tab_way.push_back(way);
        tab_mask.push_back(mask);
        tab_test.push_back(name);
    endtask

    task automatic build_table();
        int w;
        int idx;
        int gap;
        for (int i = 0; i < WAYS; i++)
            add_entry(24'h0a0000 + TAG_LEN'(i), 0, -1, '0, "fill order");
        // skewed hits on ways 0 to 2.
        for (int i = 0; i < 8; i++)
        begin
            w = (i < 4) ? 0 : ((i < 6) ? 1 : 2);
            add_entry(24'h0a0000 + TAG_LEN'(w), (i == 7) ? LONG_GAP : 0, w,
                      (i == 7) ? 8'h07 : 8'h00, "resident hits");
        end
        for (int i = 0; i < 4; i++)
            add_entry(24'h0b0000 + TAG_LEN'(i), 0, -1, '0, "masked fills");
        add_entry(24'h0b0003, 0, 0, '0, "masked fills"); // wrapped back to way 0.
        add_entry(24'h0b0001, 0, 1, '0, "masked fills");
        add_entry(24'h0b0002, 0, 2, '0, "masked fills");
        // way 0 outgrows the average share.
        for (int i = 0; i < 9; i++)
            add_entry(24'h0b0003, (i == 8) ? LONG_GAP : 0, 0,
                      (i == 8) ? 8'h01 : 8'h00, "masked fills");
        for (int i = 0; i < 16; i++)
            add_entry(24'h0c0000 + TAG_LEN'(i), (i == 15) ? LONG_GAP : 0, -1,
                      (i == 15) ? 8'hff : 8'h00, "no-hit epoch");
        for (int i = 0; i < RANDOM_COUNT; i++)
        begin
            take_bits(4, idx); // small pool so hits occur.
            take_bits(2, gap);
            add_entry(24'h0d0000 + TAG_LEN'(idx), gap, -2, '0, "random epochs");
        end
    endtask

    task automatic tick();
        @(posedge clk_in);
        edge_n++;
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("test %s: %0d errors", name, error_count - errors_before);
    endtask

    initial
    begin
        logic [WAYS - 1:0] exp_hv;
        int                max_gap;
        int                errors_before;

        access_valid             = 1'b0;
        access_tag               = '0;
        reset_with_request_limit = 1'b1;
        error_count              = 0;
        check_count              = 0;
        edge_n                   = 0;
        model_reset();
        build_table();

        max_gap = 0;
        foreach (tab_gap[i])
            if (tab_gap[i] > max_gap)
                max_gap = tab_gap[i];
        cycle_limit = tab_tag.size() * (max_gap + 4)
                    + (tab_tag.size() / int'(REQUEST_LIMIT)) * (2 * WAYS + 8) + 64;

        repeat (16) @(posedge clk_in);
        reset_with_request_limit <= 1'b0;

        errors_before = 0;
        for (int i = 0; i < tab_tag.size(); i++)
        begin
            if (i > 0 && tab_test[i] != tab_test[i - 1])
            begin
                report_test(tab_test[i - 1], errors_before);
                errors_before = error_count;
            end
            tick();
            access_valid <= 1'b1;
            access_tag   <= tab_tag[i];
            tick();
            access_valid <= 1'b0;
            model_access(tab_tag[i], edge_n, exp_hv);
            @(negedge clk_in);
            check_hit_vec(hit_vec, exp_hv);
            if (tab_way[i] == -1)
                check_hit_vec(hit_vec, '0);
            else if (tab_way[i] >= 0)
                check_hit_vec(hit_vec, WAYS'(1) << tab_way[i]);
            model_catch_up(edge_n);
            check_waymask(suggested_waymask, m_mask);
            repeat (tab_gap[i]) tick();
            if (tab_mask[i] != '0)
            begin
                @(negedge clk_in);
                check_waymask(suggested_waymask, tab_mask[i]);
            end
        end

        // let the last mask sequence settle.
        repeat (LONG_GAP) tick();
        @(negedge clk_in);
        model_catch_up(edge_n);
        check_waymask(suggested_waymask, m_mask);
        report_test(tab_test[tab_test.size() - 1], errors_before);

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* src/autocat_top.sv */
`timescale 1ns/1ps
`default_nettype none

module autocat_top import autocat_pkg::*;
#(
    parameter int            WAYS          = default_ways,
    parameter int            COUNTER_LEN   = default_counter_len,
    parameter int            TAG_LEN       = default_tag_len,
    parameter access_count_t REQUEST_LIMIT = default_request_limit
)
(
    input  wire                 clk_in,
    input  wire                 reset_with_request_limit,
    input  wire                 access_valid,
    input  wire [TAG_LEN - 1:0] access_tag,
    output wire [WAYS - 1:0]    hit_vec,
    output wire [WAYS - 1:0]    suggested_waymask
);

    wire                            lookup_done;
    wire                            epoch_end;
    wire [WAYS * COUNTER_LEN - 1:0] counter_flat;

    way_tag_array #(
        .WAYS    (WAYS),
        .TAG_LEN (TAG_LEN)
    ) tags0 (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .access_valid             (access_valid),
        .access_tag               (access_tag),
        .suggested_waymask        (suggested_waymask),
        .hit_vec                  (hit_vec),
        .lookup_done              (lookup_done)
    );

    hit_counter_array #(
        .WAYS        (WAYS),
        .COUNTER_LEN (COUNTER_LEN)
    ) counters0 (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .hit_vec                  (hit_vec),
        .epoch_end                (epoch_end),
        .counter_flat             (counter_flat)
    );

    // closes the epoch after REQUEST_LIMIT lookups.
    epoch_control #(
        .REQUEST_LIMIT (REQUEST_LIMIT)
    ) epoch0 (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .lookup_done              (lookup_done),
        .epoch_end                (epoch_end)
    );

    waymask_suggest #(
        .WAYS        (WAYS),
        .COUNTER_LEN (COUNTER_LEN)
    ) suggest0 (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .epoch_end                (epoch_end),
        .counter_flat             (counter_flat),
        .suggested_waymask        (suggested_waymask)
    );

endmodule

`default_nettype wire

/* src/waymask_suggest.sv */
`timescale 1ns/1ps
`default_nettype none

module waymask_suggest import autocat_pkg::*;
#(
    parameter int WAYS        = default_ways,
    parameter int COUNTER_LEN = default_counter_len
)
(
    input  wire                              clk_in,
    input  wire                              reset_with_request_limit,
    input  wire                              epoch_end,
    input  wire [WAYS * COUNTER_LEN - 1:0]   counter_flat,
    output logic [WAYS - 1:0]                suggested_waymask
);

    localparam int IDX_W = $clog2(WAYS);
    localparam int SUM_W = COUNTER_LEN + IDX_W;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_SUM   = 2'd1;
    localparam logic [1:0] ST_CMP   = 2'd2;
    localparam logic [1:0] ST_APPLY = 2'd3;

    logic [COUNTER_LEN - 1:0] snap [WAYS];
    logic [1:0]               state;
    logic [IDX_W - 1:0]       idx;
    logic [SUM_W - 1:0]       total;
    logic [SUM_W - 1:0]       scaled;
    logic [WAYS - 1:0]        next_mask;

    assign scaled = {snap[idx], {IDX_W{1'b0}}}; // count times WAYS.

    // counter snapshot.
    always_ff @(posedge clk_in)
    begin
        if (epoch_end)
        begin
            for (int w = 0; w < WAYS; w++)
            begin
                snap[w] <= counter_flat[w * COUNTER_LEN +: COUNTER_LEN];
            end
        end
    end

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
        begin
            state             <= ST_IDLE;
            idx               <= '0;
            total             <= '0;
            next_mask         <= '0;
            suggested_waymask <= '1;
        end
        else if (epoch_end)
        begin
            state <= ST_SUM;
            idx   <= '0;
            total <= '0;
        end
        else
        begin
            case (state)
                ST_SUM:
                begin
                    total <= total + SUM_W'(snap[idx]);
                    idx   <= idx + 1'b1;
                    if (idx == IDX_W'(WAYS - 1))
                        state <= ST_CMP; // idx wraps to 0.
                end
                ST_CMP:
                begin
                    next_mask[idx] <= scaled >= total;
                    idx            <= idx + 1'b1;
                    if (idx == IDX_W'(WAYS - 1))
                        state <= ST_APPLY;
                end
                ST_APPLY:
                begin
                    // no hits at all, keep every way open.
                    suggested_waymask <= (total == '0) ? '1 : next_mask;
                    state             <= ST_IDLE;
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/epoch_control.sv */
`timescale 1ns/1ps
`default_nettype none

module epoch_control import autocat_pkg::*;
#(
    parameter access_count_t REQUEST_LIMIT = default_request_limit
)
(
    input  wire  clk_in,
    input  wire  reset_with_request_limit,
    input  wire  lookup_done,
    output logic epoch_end
);

    access_count_t request_count;
    logic          limit_hit;

    assign limit_hit = lookup_done && (request_count == REQUEST_LIMIT - 1'b1);

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
        begin
            request_count <= '0;
            epoch_end     <= 1'b0;
        end
        else
        begin
            // one cycle late, after the last hit is counted.
            epoch_end <= limit_hit;

            if (limit_hit)
                request_count <= '0; // epoch clear.
            else if (lookup_done)
                request_count <= request_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/hit_counter_array.sv */
`timescale 1ns/1ps
`default_nettype none

module hit_counter_array import autocat_pkg::*;
#(
    parameter int WAYS        = default_ways,
    parameter int COUNTER_LEN = default_counter_len
)
(
    input  wire                                clk_in,
    input  wire                                reset_with_request_limit,
    input  wire [WAYS - 1:0]                   hit_vec,
    input  wire                                epoch_end,
    output logic [WAYS * COUNTER_LEN - 1:0]    counter_flat
);

    logic [WAYS - 1:0] hit_vec_pre;
    logic [WAYS - 1:0] hit_rise;

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
            hit_vec_pre <= '0;
        else
            hit_vec_pre <= hit_vec;
    end

    assign hit_rise = hit_vec & ~hit_vec_pre; // one count per hit pulse.

    for (genvar gen = 0; gen < WAYS; gen++)
    begin : g_way
        logic [COUNTER_LEN - 1:0] hit_counter;

        assign counter_flat[gen * COUNTER_LEN +: COUNTER_LEN] = hit_counter;

        always_ff @(posedge clk_in or posedge reset_with_request_limit)
        begin
            if (reset_with_request_limit)
            begin
                hit_counter <= '0;
            end
            else if (epoch_end)
            begin
                // snapshot taken downstream on this edge.
                hit_counter <= '0;
            end
            else if (hit_rise[gen] && hit_counter != '1)
            begin
                hit_counter <= hit_counter + 1'b1; // holds at max.
            end
        end
    end

endmodule

`default_nettype wire

/* src/way_tag_array.sv */
`timescale 1ns/1ps
`default_nettype none

module way_tag_array import autocat_pkg::*;
#(
    parameter int WAYS    = default_ways,
    parameter int TAG_LEN = default_tag_len
)
(
    input  wire                 clk_in,
    input  wire                 reset_with_request_limit,
    input  wire                 access_valid,
    input  wire [TAG_LEN - 1:0] access_tag,
    input  wire [WAYS - 1:0]    suggested_waymask,
    output logic [WAYS - 1:0]   hit_vec,
    output logic                lookup_done
);

    localparam int IDX_W = $clog2(WAYS);

    logic [TAG_LEN - 1:0] tag_mem [WAYS];
    logic [WAYS - 1:0]    tag_valid;
    logic [WAYS - 1:0]    match;
    logic [IDX_W - 1:0]   last_victim;
    logic [IDX_W - 1:0]   victim;
    logic [IDX_W - 1:0]   cand;
    logic                 miss;

    // parallel compare against every way.
    always_comb
    begin
        for (int w = 0; w < WAYS; w++)
        begin
            match[w] = tag_valid[w] && (tag_mem[w] == access_tag);
        end
    end

    assign miss = ~|match;

    // next allowed way above the last victim, wrapping.
    // walks downward so the nearest candidate is the one kept.
    always_comb
    begin
        victim = last_victim + 1'b1; // empty mask, plain round robin.
        for (int k = WAYS; k >= 1; k--)
        begin
            cand = last_victim + IDX_W'(k);
            if (suggested_waymask[cand])
                victim = cand;
        end
    end

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
        begin
            hit_vec     <= '0;
            lookup_done <= 1'b0;
            tag_valid   <= '0;
            last_victim <= IDX_W'(WAYS - 1); // first fill lands in way 0.
        end
        else
        begin
            lookup_done <= access_valid;
            if (access_valid)
            begin
                hit_vec <= match;
                if (miss)
                begin
                    tag_valid[victim] <= 1'b1;
                    last_victim       <= victim;
                end
            end
            else
            begin
                hit_vec <= '0;
            end
        end
    end

    // tag payload.
    always_ff @(posedge clk_in)
    begin
        if (access_valid && miss)
            tag_mem[victim] <= access_tag;
    end

endmodule

`default_nettype wire

/* src/autocat_pkg.sv */
`default_nettype none

package autocat_pkg;

    // associativity of the sampled set, power of two.
    localparam int default_ways = 16;

    localparam int default_counter_len = 16; // bits per hit counter.
    localparam int default_tag_len     = 24;

    // accesses that make up one epoch.
    localparam int default_request_limit = 64;

    typedef logic [31:0] access_count_t;

endpackage

`default_nettype wire
